/* files.f */
sobel_cfg_pkg.sv
sobel_types_pkg.sv
sobel_if.sv
line_buffer.sv
line_window.sv
sobel_gradient.sv
edge_threshold.sv
sobel_top.sv
tb_clock.sv
tb_sobel.sv

/* run.sh */
#!/bin/sh
# build and run the sobel testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_sobel -f files.f

out=$(./obj_dir/Vtb_sobel)
echo "$out"

if echo "$out" | grep -q "^TESTBENCH PASSED$"; then
    exit 0
else
    exit 1
fi

/* tb_sobel.sv */
// testbench for the streaming sobel edge detector
// directed frames through the whole pipeline. every result is compared
// with a reference edge map built from zero padding, the sobel kernels
// and a squared magnitude strictly above the threshold

`timescale 1ns/1ps

module tb_sobel
    import sobel_cfg_pkg::*;
    import sobel_types_pkg::*;
();

    // seven full frames plus one cut by reset and a factor 4 for random stalls
    localparam int num_frames = 8;
    localparam int max_cycles = num_frames * (img_width + 1) * (img_height + 1) * 4 + 1000;

    logic   clk;
    logic   por_n;
    logic   soft_rst_n;       // mid-frame reset request
    logic   rst_n;
    logic   pix_valid;
    logic   pix_ready;
    pixel_t pix;
    logic   edge_valid;
    logic   edge_ready;
    logic   edge_bit;
    logic   edge_last;

    pixel_t      cur_frame   [img_height][img_width];
    pixel_t      saved_frame [img_height][img_width];   // random image kept for the stall test
    pixel_t      in_q [$];                               // pixels still to send
    logic        exp_q [$];                              // expected edge bits in raster order
    logic        exp_last_q [$];
    logic [15:0] lfsr_state;
    int          error_count;
    int          tests_run;
    int          tests_failed;
    int          cycle_count = 0;

    tb_clock i_clock (
        .clk   (clk),
        .rst_n (por_n)
    );

    assign rst_n = por_n && soft_rst_n;

    sobel_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .pix_valid  (pix_valid),
        .pix_ready  (pix_ready),
        .pix        (pix),
        .edge_valid (edge_valid),
        .edge_ready (edge_ready),
        .edge_bit   (edge_bit),
        .edge_last  (edge_last)
    );

    // watchdog that ends a run which stopped making progress
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // random source and reference model
    ////////////////////////////////////////////////////////////

    // 16 bit galois lfsr with x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic int unsigned take_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // image tap that reads zero outside the frame
    function automatic int tap(input int r, input int c);
        if (r < 0 || r >= img_height || c < 0 || c >= img_width) begin
            return 0;
        end
        return int'(cur_frame[r][c]);
    endfunction

    // append cur_frame to the stimulus and its edge map to the expected queues
    task automatic queue_frame();
        int gx;
        int gy;
        int wx;
        int wy;
        for (int r = 0; r < img_height; r++) begin
            for (int c = 0; c < img_width; c++) begin
                gx = 0;
                gy = 0;
                for (int dr = -1; dr <= 1; dr++) begin
                    for (int dc = -1; dc <= 1; dc++) begin
                        wx = (dr == 0) ? 2 : 1;          // centre row doubled in gx
                        wy = (dc == 0) ? 2 : 1;          // centre column doubled in gy
                        gx += dc * wx * tap(r + dr, c + dc);
                        gy += dr * wy * tap(r + dr, c + dc);
                    end
                end
                in_q.push_back(cur_frame[r][c]);
                exp_q.push_back((gx * gx + gy * gy) > int'(edge_threshold_sq));
                exp_last_q.push_back((r == img_height - 1) && (c == img_width - 1));
            end
        end
    endtask

    task automatic load_random_frame();
        for (int r = 0; r < img_height; r++) begin
            for (int c = 0; c < img_width; c++) begin
                cur_frame[r][c] = pixel_t'(take_bits(pixel_bits));
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_edge(input int idx, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch edge_bit at pixel %0d: got 0x%h expected 0x%h", idx, got, exp);
            error_count++;
        end
    endtask

    task automatic check_last(input int idx, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch edge_last at pixel %0d: got 0x%h expected 0x%h", idx, got, exp);
            error_count++;
        end
    endtask

    // handshake levels such as edge_valid and pix_ready
    task automatic verify_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stream driver and monitor
    ////////////////////////////////////////////////////////////

    // drive on the falling edge, sample 1 ns later once ready has settled
    task automatic stream_frames(input logic stall);
        int   in_idx;
        int   out_idx;
        logic holding;                                   // offered pixel not yet taken
        logic gap;
        in_idx  = 0;
        out_idx = 0;
        holding = 1'b0;
        while (out_idx < exp_q.size()) begin
            @(negedge clk);
            if (!holding) begin
                gap = 1'b0;
                if (stall) gap = (take_bits(2) == 0);    // roughly one cycle in four idle
                if (in_idx < in_q.size() && !gap) begin
                    pix_valid = 1'b1;
                    pix       = in_q[in_idx];
                    holding   = 1'b1;
                end else begin
                    pix_valid = 1'b0;
                    pix       = '0;
                end
            end
            edge_ready = stall ? (take_bits(2) != 0) : 1'b1;
            #1;
            if (pix_valid && pix_ready) begin
                in_idx++;
                holding = 1'b0;
            end
            if (edge_valid && edge_ready) begin
                check_edge(out_idx, edge_bit, exp_q[out_idx]);
                check_last(out_idx, edge_last, exp_last_q[out_idx]);
                out_idx++;
            end
        end
        if (in_idx != in_q.size()) begin
            $display("error: %0d of %0d pixels were accepted", in_idx, in_q.size());
            error_count++;
        end
        @(negedge clk);
        pix_valid  = 1'b0;
        pix        = '0;
        edge_ready = 1'b1;
        // nothing may follow the frame's last result
        repeat (12) begin
            #1;
            if (edge_valid) begin
                $display("error: extra result after the frame was complete");
                error_count++;
            end
            @(negedge clk);
        end
        in_q.delete();
        exp_q.delete();
        exp_last_q.delete();
    endtask

    // offer the first n queued pixels and drain outputs unchecked
    task automatic send_pixels(input int n);
        int sent;
        sent = 0;
        while (sent < n) begin
            @(negedge clk);
            pix_valid  = 1'b1;
            pix        = in_q[sent];
            edge_ready = 1'b1;
            #1;
            if (pix_ready) sent++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (error_count == errs_before) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail, %0d errors", tests_run, name,
                     error_count - errs_before);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic flat_image();
        int errs;
        errs = error_count;
        for (int r = 0; r < img_height; r++) begin
            for (int c = 0; c < img_width; c++) begin
                cur_frame[r][c] = pixel_t'(100);         // edges only from border padding
            end
        end
        queue_frame();
        stream_frames(1'b0);
        report_test("flat image", errs);
    endtask

    task automatic vertical_step();
        int errs;
        errs = error_count;
        for (int r = 0; r < img_height; r++) begin
            for (int c = 0; c < img_width; c++) begin
                cur_frame[r][c] = (c < img_width / 2) ? pixel_t'(0) : pixel_t'(200);
            end
        end
        queue_frame();
        stream_frames(1'b0);
        report_test("vertical step", errs);
    endtask

    task automatic random_image();
        int errs;
        errs = error_count;
        load_random_frame();
        saved_frame = cur_frame;
        queue_frame();
        stream_frames(1'b0);
        report_test("random image", errs);
    endtask

    task automatic random_stalls();
        int errs;
        errs = error_count;
        cur_frame = saved_frame;                         // same image as the previous test
        queue_frame();
        stream_frames(1'b1);
        report_test("random image with stalls", errs);
    endtask

    task automatic back_to_back();
        int errs;
        errs = error_count;
        for (int r = 0; r < img_height; r++) begin
            for (int c = 0; c < img_width; c++) begin
                cur_frame[r][c] = (r == 2 || r == 3) ? pixel_t'(230) : pixel_t'(20);
            end
        end
        queue_frame();                                   // horizontal bar
        load_random_frame();
        queue_frame();                                   // then a fresh random frame
        stream_frames(1'b0);
        report_test("two frames back to back", errs);
    endtask

    task automatic reset_mid_frame();
        int errs;
        errs = error_count;
        for (int r = 0; r < img_height; r++) begin
            for (int c = 0; c < img_width; c++) begin
                cur_frame[r][c] = pixel_t'(r * 40 + c * 30);   // diagonal ramp
            end
        end
        queue_frame();
        send_pixels(20);                                 // part way into row 2
        @(negedge clk);
        soft_rst_n = 1'b0;
        pix_valid  = 1'b0;
        repeat (2) @(negedge clk);
        #1;
        verify_level("edge_valid", edge_valid, 1'b0);
        check_last(-1, edge_last, 1'b0);
        @(negedge clk);
        soft_rst_n = 1'b1;
        @(negedge clk);
        #1;
        verify_level("edge_valid", edge_valid, 1'b0);
        check_last(-1, edge_last, 1'b0);
        verify_level("pix_ready", pix_ready, 1'b1);      // back in FILL
        in_q.delete();
        exp_q.delete();
        exp_last_q.delete();
        queue_frame();
        stream_frames(1'b0);
        report_test("reset in mid frame", errs);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        pix_valid    = 1'b0;
        pix          = '0;
        edge_ready   = 1'b0;
        soft_rst_n   = 1'b1;
        lfsr_state   = 16'd27;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        wait (por_n == 1'b1);

        flat_image();
        vertical_step();
        random_image();
        random_stalls();
        back_to_back();
        reset_mid_frame();

        $display("summary: %0d tests, %0d failed, %0d errors",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* tb_clock.sv */
// testbench clock and reset source
// free running 20 ns clock, power-on reset held low for three
// rising edges and released on a falling edge

`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    localparam int half_period_ns = 10;   // 20 ns period
    localparam int reset_cycles   = 3;

    initial begin
        clk = 1'b0;
        forever #(half_period_ns) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;                     // release away from the active edge
    end

endmodule

/* sobel_top.sv */
// sobel edge detector top level
// raster pixel stream in, one edge bit per pixel out, both valid/ready.
// three stages: window build, gradient, threshold
// back-pressure on edge_ready reaches pix_ready stage by stage

`timescale 1ns/1ps

module sobel_top
    import sobel_types_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,

    // pixel stream in
    input  logic   pix_valid,
    output logic   pix_ready,
    input  pixel_t pix,

    // edge stream out
    output logic   edge_valid,
    input  logic   edge_ready,
    output logic   edge_bit,
    output logic   edge_last      // with the frame's final pixel
);

    ////////////////////////////////////////////////////////////
    // stage links
    ////////////////////////////////////////////////////////////

    window_if i_win_if ();
    grad_if   i_grad_if ();

    ////////////////////////////////////////////////////////////
    // stages
    ////////////////////////////////////////////////////////////

    line_window i_line_window (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_valid (pix_valid),
        .pix       (pix),
        .pix_ready (pix_ready),
        .win_out   (i_win_if.source)
    );

    sobel_gradient i_sobel_gradient (
        .clk      (clk),
        .rst_n    (rst_n),
        .win_in   (i_win_if.sink),
        .grad_out (i_grad_if.source)
    );

    edge_threshold i_edge_threshold (
        .clk        (clk),
        .rst_n      (rst_n),
        .grad_in    (i_grad_if.sink),
        .edge_valid (edge_valid),
        .edge_ready (edge_ready),
        .edge_bit   (edge_bit),
        .edge_last  (edge_last)
    );

endmodule

/* edge_threshold.sv */
// edge threshold stage
// squares and sums the two gradients, flags an edge when the sum is
// strictly above the threshold and registers the result for the
// output stream together with the frame end flag

`timescale 1ns/1ps

module edge_threshold
    import sobel_cfg_pkg::*;
    import sobel_types_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    grad_if.sink   grad_in,
    output logic   edge_valid,
    input  logic   edge_ready,
    output logic   edge_bit,
    output logic   edge_last
);

    logic [mag_bits-1:0] mag;    // gx^2 + gy^2
    logic                is_edge;

    // square of a signed gradient as an unsigned magnitude
    function automatic logic [mag_bits-1:0] square(input grad_t g);
        logic signed [mag_bits-1:0] g_ext;
        g_ext  = mag_bits'(g);                       // sign extend first
        square = unsigned'(g_ext * g_ext);
    endfunction

    ////////////////////////////////////////////////////////////
    // magnitude and decision
    ////////////////////////////////////////////////////////////

    assign mag     = square(grad_in.gx) + square(grad_in.gy);
    assign is_edge = (mag > edge_threshold_sq);     // strict compare

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////

    assign grad_in.ready = !edge_valid || edge_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            edge_valid <= 1'b0;
            edge_last  <= 1'b0;
        end else if (grad_in.ready) begin
            edge_valid <= grad_in.valid;
            edge_last  <= grad_in.valid && grad_in.last;   // flag only with data
        end
    end

    always_ff @(posedge clk) begin
        if (grad_in.valid && grad_in.ready) begin
            edge_bit <= is_edge;
        end
    end

    a_last_with_valid : assert property (
        @(posedge clk) disable iff (!rst_n)
        edge_last |-> edge_valid
    );

endmodule

/* sobel_gradient.sv */
// sobel gradient stage
// applies the horizontal and vertical sobel kernels to one window
// and registers gx/gy with the handshake, one cycle when not stalled

`timescale 1ns/1ps

module sobel_gradient
    import sobel_cfg_pkg::*;
    import sobel_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    window_if.sink   win_in,
    grad_if.source   grad_out
);

    grad_t gx_c;      // combinational kernel results
    grad_t gy_c;
    grad_t gx_q;
    grad_t gy_q;
    logic  valid_q;
    logic  last_q;

    // zero extend a pixel into the signed gradient width
    function automatic grad_t ext(input pixel_t p);
        ext = grad_t'({{(grad_bits - pixel_bits){1'b0}}, p});
    endfunction

    ////////////////////////////////////////////////////////////
    // kernels with the middle tap weighted 2
    ////////////////////////////////////////////////////////////

    // gx is the right column minus the left column
    assign gx_c = (ext(win_in.win[0][2]) + (ext(win_in.win[1][2]) <<< 1) + ext(win_in.win[2][2]))
                - (ext(win_in.win[0][0]) + (ext(win_in.win[1][0]) <<< 1) + ext(win_in.win[2][0]));

    // gy is the lower row minus the upper row
    assign gy_c = (ext(win_in.win[2][0]) + (ext(win_in.win[2][1]) <<< 1) + ext(win_in.win[2][2]))
                - (ext(win_in.win[0][0]) + (ext(win_in.win[0][1]) <<< 1) + ext(win_in.win[0][2]));

    ////////////////////////////////////////////////////////////
    // register stage
    ////////////////////////////////////////////////////////////

    assign win_in.ready = !valid_q || grad_out.ready;    // empty or draining

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (win_in.ready) begin
            valid_q <= win_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (win_in.valid && win_in.ready) begin
            gx_q   <= gx_c;
            gy_q   <= gy_c;
            last_q <= win_in.last;
        end
    end

    assign grad_out.valid = valid_q;
    assign grad_out.gx    = gx_q;
    assign grad_out.gy    = gy_q;
    assign grad_out.last  = last_q;

    // held result stays offered until taken
    a_valid_held : assert property (
        @(posedge clk) disable iff (!rst_n)
        (grad_out.valid && !grad_out.ready) |=> grad_out.valid
    );

endmodule

/* line_window.sv */
// line window unit
// takes raster pixels, keeps the two previous rows in line buffers and
// shifts one 3-tap column per step into a 3x3 window register.
// a zero column is inserted after each row, and after the last row
// a flush row of zero taps brings out the bottom row of windows.
// every emitted window is centred on its pixel with zero padding

`timescale 1ns/1ps

module line_window
    import sobel_cfg_pkg::*;
    import sobel_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     pix_valid,
    input  pixel_t   pix,
    output logic     pix_ready,
    window_if.source win_out
);

    win_state_t          state;
    logic [col_bits-1:0] col_cnt;      // column of the incoming tap column
    logic [row_bits-1:0] row_cnt;      // row of the bottom tap
    logic                can_load;     // output slot free this cycle
    logic                is_pad;       // this step is the row end padding column
    logic                step;         // a column shifts into the window
    logic                emit;         // the shift completes a window
    pixel_t              lb1_rd;       // row above
    pixel_t              lb2_rd;       // two rows above
    pixel_t              new_top;
    pixel_t              new_mid;
    pixel_t              new_bot;
    window_t             win_q;
    logic                valid_q;
    logic                last_q;

    ////////////////////////////////////////////////////////////
    // step control
    ////////////////////////////////////////////////////////////

    assign can_load  = !valid_q || win_out.ready;
    assign is_pad    = (col_cnt == col_bits'(img_width));
    assign pix_ready = can_load && !is_pad && (state != FLUSH);   // no input while padding

    // padding and flush columns need no input pixel
    assign step = can_load && (is_pad || (state == FLUSH) || pix_valid);

    // column 0 only primes the window, row 0 only fills the buffers
    assign emit = step && (state != FILL) && (col_cnt != '0);

    // new tap column, zero where the coordinate is outside the frame
    always_comb begin
        new_top = '0;
        new_mid = '0;
        new_bot = '0;
        if (!is_pad) begin
            new_bot = (state == FLUSH) ? '0 : pix;                   // row below frame
            new_mid = (state == FILL) ? '0 : lb1_rd;
            if (state == FLUSH || (state == RUN && row_cnt != row_bits'(1))) begin
                new_top = lb2_rd;                                    // row above frame stays zero
            end
        end
    end

    // buffers only move on real columns, padding does not occupy a slot
    line_buffer i_lb_above (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (step && !is_pad),
        .wr_pix  (new_bot),
        .rd_pix  (lb1_rd)
    );

    line_buffer i_lb_above2 (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (step && !is_pad),
        .wr_pix  (lb1_rd),
        .rd_pix  (lb2_rd)
    );

    ////////////////////////////////////////////////////////////
    // FSM and coordinate counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= FILL;
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (step) begin
            if (!is_pad) begin
                col_cnt <= col_cnt + col_bits'(1);
            end else begin
                col_cnt <= '0;                                       // row done
                case (state)
                    FILL: begin
                        state   <= RUN;
                        row_cnt <= row_bits'(1);
                    end
                    RUN: begin
                        if (row_cnt == row_bits'(img_height - 1)) begin
                            state <= FLUSH;                          // last real row in
                        end else begin
                            row_cnt <= row_cnt + row_bits'(1);
                        end
                    end
                    default: begin                                   // end of flush
                        state   <= FILL;
                        row_cnt <= '0;
                    end
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // window shift register and output handshake
    ////////////////////////////////////////////////////////////

    // columns move left, new column enters on the right
    always_ff @(posedge clk) begin
        if (step) begin
            for (int r = 0; r < 3; r++) begin
                win_q[r][0] <= win_q[r][1];
                win_q[r][1] <= win_q[r][2];
            end
            win_q[0][2] <= new_top;
            win_q[1][2] <= new_mid;
            win_q[2][2] <= new_bot;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else if (can_load) begin
            valid_q <= emit;
            last_q  <= emit && is_pad && (state == FLUSH);            // bottom right pixel
        end
    end

    assign win_out.valid = valid_q;
    assign win_out.win   = win_q;
    assign win_out.last  = last_q;

    // input must be held off for the whole flush row
    a_flush_no_input : assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == FLUSH) |-> !pix_ready
    );

    // a stalled window must not change under the consumer
    a_win_stable : assert property (
        @(posedge clk) disable iff (!rst_n)
        (win_out.valid && !win_out.ready) |=> (win_out.valid && $stable(win_out.win))
    );

endmodule

/* line_buffer.sv */
// line buffer
// one row of pixels in a circular memory. every advance returns the
// pixel written one row earlier at the same column and stores the new
// one in its place, so a chain of two gives the two rows above

`timescale 1ns/1ps

module line_buffer
    import sobel_cfg_pkg::*;
    import sobel_types_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   advance,    // read and replace the current slot
    input  pixel_t wr_pix,     // pixel stored this access
    output pixel_t rd_pix      // pixel from one row earlier
);

    typedef logic [$clog2(img_width)-1:0] ptr_t;

    pixel_t mem [img_width];   // one row of pixels
    ptr_t   ptr;               // current column slot

    ////////////////////////////////////////////////////////////
    // read old, write new in the same slot
    ////////////////////////////////////////////////////////////

    assign rd_pix = mem[ptr];  // combinational read before the advance

    always_ff @(posedge clk) begin
        if (advance) begin
            mem[ptr] <= wr_pix;
        end
    end

    // pointer wraps at row end
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (advance) begin
            if (ptr == ptr_t'(img_width - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + ptr_t'(1);
            end
        end
    end

endmodule

/* sobel_if.sv */
// internal stream interfaces of the sobel pipeline
// window_if carries one zero-padded 3x3 window per pixel,
// grad_if carries the gx/gy pair of that pixel
// both use valid/ready and transfer when both are high

`timescale 1ns/1ps

////////////////////////////////////////////////////////////
// window stream from line_window to sobel_gradient
////////////////////////////////////////////////////////////

interface window_if import sobel_types_pkg::*; ();

    logic    valid;   // window present
    logic    ready;   // consumer can take it
    window_t win;     // centred on the current pixel
    logic    last;    // final window of the frame

    modport source (
        output valid,
        output win,
        output last,
        input  ready
    );

    modport sink (
        input  valid,
        input  win,
        input  last,
        output ready
    );

endinterface

////////////////////////////////////////////////////////////
// gradient stream from sobel_gradient to edge_threshold
////////////////////////////////////////////////////////////

interface grad_if import sobel_types_pkg::*; ();

    logic  valid;
    logic  ready;
    grad_t gx;        // horizontal gradient
    grad_t gy;        // vertical gradient
    logic  last;      // travels with the frame's final pixel

    modport source (
        output valid,
        output gx,
        output gy,
        output last,
        input  ready
    );

    modport sink (
        input  valid,
        input  gx,
        input  gy,
        input  last,
        output ready
    );

endinterface

/* sobel_types_pkg.sv */
// sobel datapath types
// pixel, 3x3 window and gradient types shared between the stages,
// plus the state encoding of the window unit

package sobel_types_pkg;

    import sobel_cfg_pkg::*;

    ////////////////////////////////////////////////////////////
    // data types
    ////////////////////////////////////////////////////////////

    // one unsigned grayscale pixel
    typedef logic [pixel_bits-1:0] pixel_t;

    // 3x3 neighbourhood, indexed [row][col]
    // row 0 is the upper row, col 0 the left column, 72 bits packed
    typedef pixel_t [0:2][0:2] window_t;

    // signed gradient result of one kernel
    typedef logic signed [grad_bits-1:0] grad_t;

    ////////////////////////////////////////////////////////////
    // window unit FSM
    ////////////////////////////////////////////////////////////

    // FILL fills the line buffers from the first row of a frame
    // RUN gives one window per pixel for rows 1 .. img_height-1
    // FLUSH drives the virtual row below the frame from zero padding
    typedef enum logic [1:0] {
        FILL  = 2'd0,
        RUN   = 2'd1,
        FLUSH = 2'd2
    } win_state_t;

endpackage

/* sobel_cfg_pkg.sv */
// sobel configuration package
// image geometry, datapath widths and the edge decision threshold
// for the streaming lane-detection edge detector

package sobel_cfg_pkg;

    ////////////////////////////////////////////////////////////
    // image geometry
    ////////////////////////////////////////////////////////////

    localparam int img_width  = 8;                    // pixels per row
    localparam int img_height = 6;                    // rows per frame

    // column counter also reaches img_width for the padding column
    localparam int col_bits = $clog2(img_width + 1);
    localparam int row_bits = $clog2(img_height);     // rows 0 .. img_height-1

    ////////////////////////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////////////////////////

    localparam int pixel_bits = 8;                    // grayscale sample
    localparam int grad_bits  = 11;                   // signed, covers +/-1020
    localparam int mag_bits   = 22;                   // gx^2 + gy^2 worst case < 2^21

    // squared magnitude must be strictly above this to flag an edge
    // 22500 = 150^2
    localparam logic [mag_bits-1:0] edge_threshold_sq = mag_bits'(22500);

endpackage
